//--- common/dmr_rf_consts.svh
// ***************************************************************************
// dmr register file constants
// ***************************************************************************

`ifndef DMR_RF_CONSTS_SVH
`define DMR_RF_CONSTS_SVH

// number of architectural registers per file
`define DMR_RF_NUM_REGS 16

// register address width, log2 of the register count
`define DMR_RF_ADDR_W 4

// register data width
`define DMR_RF_DATA_W 32

`endif

//--- common/dmr_rf_pkg.sv
// ***************************************************************************
// dmr register file types
// ***************************************************************************

`include "dmr_rf_consts.svh"

package dmr_rf_pkg;

  // ************************************************************************
  // register file ports
  // ************************************************************************

  // one write port, same layout for core a, core b, shadow and refill
  // 1 + 4 + 32 = 37 bits
  typedef struct packed {
    // write enable
    logic                      we;
    // destination register
    logic [`DMR_RF_ADDR_W-1:0] addr;
    // write data
    logic [`DMR_RF_DATA_W-1:0] data;
  } rf_wr_t;

  // read port request, address only
  typedef struct packed {
    logic [`DMR_RF_ADDR_W-1:0] addr;
  } rf_rd_t;

  // ************************************************************************
  // recovery controller
  // ************************************************************************

  // idle until mismatch, halt handshake, refill walk, wait for ack low
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    HALT_REQ = 2'd1,
    REFILL   = 2'd2,
    RELEASE  = 2'd3
  } rec_state_e;

endpackage

//--- source/tmr_bitwise_voter.sv
// ***************************************************************************
// bitwise tmr majority voter
// ***************************************************************************

`timescale 1ns/10ps

`include "dmr_rf_consts.svh"

module tmr_bitwise_voter #(
  parameter int unsigned DATA_W = `DMR_RF_ADDR_W
) (
  input  logic [DATA_W-1:0] a_i,
  input  logic [DATA_W-1:0] b_i,
  input  logic [DATA_W-1:0] c_i,
  output logic [DATA_W-1:0] majority_o,
  output logic              error_o
);

  // per bit disagreement between any pair
  logic [DATA_W-1:0] diff;

  // two of three per bit
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // a bit disagrees if a differs from b or from c
  // b vs c alone is covered by these two
  assign diff = (a_i ^ b_i) | (a_i ^ c_i);

  // any disagreeing bit flags the vote
  assign error_o = |diff;

endmodule

//--- recovery/rf_refill_addr_gen.sv
// ***************************************************************************
// triplicated refill address generator
// ***************************************************************************

`timescale 1ns/10ps

`include "dmr_rf_consts.svh"

module rf_refill_addr_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      enable_i,
  output logic                      done_o,
  output logic                      fatal_o,
  output logic [`DMR_RF_ADDR_W-1:0] address_o
);

  // counters wrap back to zero after the last register index
  localparam logic [`DMR_RF_ADDR_W-1:0] last_addr = `DMR_RF_ADDR_W'(`DMR_RF_NUM_REGS - 1);

  // three independent copies of the counter
  logic [2:0][`DMR_RF_ADDR_W-1:0] cnt_q;
  // per copy wrap flag
  logic [2:0]                     cnt_last;
  // voter disagreement
  logic                           vote_err;

  for (genvar i = 0; i < 3; i++) begin : g_cnt
    // copy i has reached the last address
    assign cnt_last[i] = (cnt_q[i] == last_addr);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (clear_i || cnt_last[i]) begin
        // restart from register 0
        cnt_q[i] <= '0;
      end else if (enable_i) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  // majority of the three copies is the refill address
  tmr_bitwise_voter #(
    .DATA_W(`DMR_RF_ADDR_W)
  ) u_addr_voter (
    .a_i       (cnt_q[0]),
    .b_i       (cnt_q[1]),
    .c_i       (cnt_q[2]),
    .majority_o(address_o),
    .error_o   (vote_err)
  );

  // any copy at the end marks the final step
  assign done_o  = |cnt_last;
  assign fatal_o = vote_err;

endmodule

//--- recovery/rf_recovery_ctrl.sv
// ***************************************************************************
// register file recovery controller
// ***************************************************************************

`timescale 1ns/10ps

`include "dmr_rf_consts.svh"

module rf_recovery_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      mismatch_i,
  input  logic                      rec_ack_i,
  output logic                      rec_req_o,
  output logic                      busy_o,
  output logic                      err_o,
  output logic                      fatal_o,
  output dmr_rf_pkg::rf_wr_t        refill_o,
  output dmr_rf_pkg::rf_rd_t        shadow_rd_o,
  input  logic [`DMR_RF_DATA_W-1:0] shadow_data_i
);

  dmr_rf_pkg::rec_state_e state_q, state_d;

  // sticky flags
  logic err_q;
  logic fatal_q;

  // address generator handshake
  logic                      gen_clear;
  logic                      gen_enable;
  logic                      gen_done;
  logic                      gen_fatal;
  logic [`DMR_RF_ADDR_W-1:0] gen_addr;

  // ************************************************************************
  // state machine
  // ************************************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      // wait for a registered mismatch pulse
      dmr_rf_pkg::IDLE: begin
        if (mismatch_i) state_d = dmr_rf_pkg::HALT_REQ;
      end
      // req high, wait for both cores halted
      dmr_rf_pkg::HALT_REQ: begin
        if (rec_ack_i) state_d = dmr_rf_pkg::REFILL;
      end
      // one register per cycle, leave after the last copy
      dmr_rf_pkg::REFILL: begin
        if (gen_done) state_d = dmr_rf_pkg::RELEASE;
      end
      // req low, wait for ack low to close the handshake
      dmr_rf_pkg::RELEASE: begin
        if (!rec_ack_i) state_d = dmr_rf_pkg::IDLE;
      end
      default: state_d = dmr_rf_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dmr_rf_pkg::IDLE;
      err_q   <= 1'b0;
      fatal_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // err set on detection, cleared when recovery ends
      if (state_q == dmr_rf_pkg::IDLE && mismatch_i) begin
        err_q <= 1'b1;
      end else if (state_q == dmr_rf_pkg::RELEASE && !rec_ack_i) begin
        err_q <= 1'b0;
      end
      // counter upset stays latched until reset
      if (gen_fatal) fatal_q <= 1'b1;
    end
  end

  // ************************************************************************
  // refill address and write port
  // ************************************************************************

  // counter held at zero while idle, steps only in refill
  assign gen_clear  = (state_q == dmr_rf_pkg::IDLE);
  assign gen_enable = (state_q == dmr_rf_pkg::REFILL);

  rf_refill_addr_gen u_addr_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (gen_clear),
    .enable_i (gen_enable),
    .done_o   (gen_done),
    .fatal_o  (gen_fatal),
    .address_o(gen_addr)
  );

  // shadow entry at the current address goes to both cores
  assign shadow_rd_o.addr = gen_addr;
  assign refill_o.we      = gen_enable;
  assign refill_o.addr    = gen_addr;
  assign refill_o.data    = shadow_data_i;

  assign rec_req_o = (state_q == dmr_rf_pkg::HALT_REQ) || (state_q == dmr_rf_pkg::REFILL);
  assign busy_o    = (state_q != dmr_rf_pkg::IDLE);
  assign err_o     = err_q;
  assign fatal_o   = fatal_q;

endmodule

//--- source/core_reg_file.sv
// ***************************************************************************
// flip-flop register file
// ***************************************************************************

`timescale 1ns/10ps

`include "dmr_rf_consts.svh"

module core_reg_file (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dmr_rf_pkg::rf_wr_t        wr_i,
  input  dmr_rf_pkg::rf_rd_t        rd_i,
  output logic [`DMR_RF_DATA_W-1:0] rd_data_o
);

  // register storage with one entry per architectural register
  logic [`DMR_RF_NUM_REGS-1:0][`DMR_RF_DATA_W-1:0] regs_q;

  // ************************************************************************
  // write port
  // ************************************************************************

  // all entries start at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (wr_i.we) begin
      // single write per cycle
      regs_q[wr_i.addr] <= wr_i.data;
    end
  end

  // ************************************************************************
  // read port
  // ************************************************************************

  // a write shows on the combinational read from the next cycle on
  assign rd_data_o = regs_q[rd_i.addr];

endmodule

//--- source/dmr_rf_top.sv
// ***************************************************************************
// dmr register file with shadow recovery
// ***************************************************************************

`timescale 1ns/10ps

`include "dmr_rf_consts.svh"

module dmr_rf_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      rec_ack_i,
  input  dmr_rf_pkg::rf_wr_t        wr_a_i,
  input  dmr_rf_pkg::rf_wr_t        wr_b_i,
  input  dmr_rf_pkg::rf_rd_t        rd_a_i,
  input  dmr_rf_pkg::rf_rd_t        rd_b_i,
  output logic [`DMR_RF_DATA_W-1:0] rd_data_a_o,
  output logic [`DMR_RF_DATA_W-1:0] rd_data_b_o,
  output logic                      rec_req_o,
  output logic                      busy_o,
  output logic                      err_o,
  output logic                      fatal_o
);

  // core writes accepted, no recovery pending or running
  logic                      core_open;
  logic                      mismatch;
  logic                      mismatch_q;

  // refill path from the controller
  dmr_rf_pkg::rf_wr_t        refill;
  dmr_rf_pkg::rf_rd_t        shadow_rd;
  logic [`DMR_RF_DATA_W-1:0] shadow_data;

  // selected write per file
  dmr_rf_pkg::rf_wr_t        wr_a_sel;
  dmr_rf_pkg::rf_wr_t        wr_b_sel;
  dmr_rf_pkg::rf_wr_t        wr_shadow;

  // ************************************************************************
  // write comparator
  // ************************************************************************

  // pending pulse counts as busy, so a second write cannot slip through
  assign core_open = !busy_o && !mismatch_q;

  // enables differ, or both set with differing address or data
  assign mismatch = core_open &&
                    ((wr_a_i.we != wr_b_i.we) ||
                     (wr_a_i.we && ((wr_a_i.addr != wr_b_i.addr) ||
                                    (wr_a_i.data != wr_b_i.data))));

  // one cycle pulse into the controller
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q <= 1'b0;
    end else begin
      mismatch_q <= mismatch;
    end
  end

  // ************************************************************************
  // write selection
  // ************************************************************************

  // refill has priority, blocked core writes are dropped
  assign wr_a_sel = busy_o ? refill : (core_open ? wr_a_i : '0);
  assign wr_b_sel = busy_o ? refill : (core_open ? wr_b_i : '0);

  // shadow only takes agreed writes, so it holds the last good state
  assign wr_shadow.we   = core_open && !mismatch && wr_a_i.we && wr_b_i.we;
  assign wr_shadow.addr = wr_a_i.addr;
  assign wr_shadow.data = wr_a_i.data;

  core_reg_file u_rf_a (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_i     (wr_a_sel),
    .rd_i     (rd_a_i),
    .rd_data_o(rd_data_a_o)
  );

  core_reg_file u_rf_b (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_i     (wr_b_sel),
    .rd_i     (rd_b_i),
    .rd_data_o(rd_data_b_o)
  );

  // shadow read port belongs to the refill walk
  core_reg_file u_rf_shadow (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_i     (wr_shadow),
    .rd_i     (shadow_rd),
    .rd_data_o(shadow_data)
  );

  rf_recovery_ctrl u_rec_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mismatch_i   (mismatch_q),
    .rec_ack_i    (rec_ack_i),
    .rec_req_o    (rec_req_o),
    .busy_o       (busy_o),
    .err_o        (err_o),
    .fatal_o      (fatal_o),
    .refill_o     (refill),
    .shadow_rd_o  (shadow_rd),
    .shadow_data_i(shadow_data)
  );

endmodule

//--- verification/tb_dmr_rf_top.sv
// ***************************************************************************
// dmr register file testbench
// ***************************************************************************

`timescale 1ns/10ps

`include "dmr_rf_consts.svh"

module tb_dmr_rf_top;

  // one recovery is under 80 cycles and a full sweep of reads takes 16
  // the six tests stay below 800 cycles with a wide margin to the limit
  localparam int cycle_limit  = 4000;
  localparam int refill_limit = 4 * `DMR_RF_NUM_REGS;

  logic                      clk;
  logic                      rst_n;
  logic                      rec_ack;
  dmr_rf_pkg::rf_wr_t        wr_a;
  dmr_rf_pkg::rf_wr_t        wr_b;
  dmr_rf_pkg::rf_rd_t        rd_a;
  dmr_rf_pkg::rf_rd_t        rd_b;
  logic [`DMR_RF_DATA_W-1:0] rd_data_a;
  logic [`DMR_RF_DATA_W-1:0] rd_data_b;
  logic                      rec_req;
  logic                      busy;
  logic                      err;
  logic                      fatal;

  // reference model of core a, core b and the shadow copy
  logic [`DMR_RF_DATA_W-1:0] model_a      [`DMR_RF_NUM_REGS];
  logic [`DMR_RF_DATA_W-1:0] model_b      [`DMR_RF_NUM_REGS];
  logic [`DMR_RF_DATA_W-1:0] model_shadow [`DMR_RF_NUM_REGS];
  logic                      model_busy;

  int          error_count;
  int          check_count;
  int          cycle_count;
  int unsigned seed_value;

  dmr_rf_top u_dmr_rf_top (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .rec_ack_i  (rec_ack),
    .wr_a_i     (wr_a),
    .wr_b_i     (wr_b),
    .rd_a_i     (rd_a),
    .rd_b_i     (rd_b),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b),
    .rec_req_o  (rec_req),
    .busy_o     (busy),
    .err_o      (err),
    .fatal_o    (fatal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ************************************************************************
  // checks
  // ************************************************************************

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
    else begin
      error_count++;
      $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string test_name, input string what,
                            input logic expected, input logic actual);
    check_count++;
    assert (actual === expected)
    else begin
      error_count++;
      $display("Error %s %s: expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic check_flags(input string test_name, input logic exp_busy,
                             input logic exp_req, input logic exp_err);
    check_flag(test_name, "busy_o", exp_busy, busy);
    check_flag(test_name, "rec_req_o", exp_req, rec_req);
    check_flag(test_name, "err_o", exp_err, err);
    // nothing upsets the counters here so the voter must agree
    check_flag(test_name, "fatal_o", 1'b0, fatal);
  endtask

  // ************************************************************************
  // reference model and stimulus
  // ************************************************************************

  function automatic logic writes_differ(input dmr_rf_pkg::rf_wr_t a,
                                         input dmr_rf_pkg::rf_wr_t b);
    return (a.we != b.we) || (a.we && ((a.addr != b.addr) || (a.data != b.data)));
  endfunction

  // writes during recovery are dropped
  function automatic void model_write(input dmr_rf_pkg::rf_wr_t a,
                                      input dmr_rf_pkg::rf_wr_t b);
    if (!model_busy) begin
      if (writes_differ(a, b)) begin
        // each core keeps its own write and the shadow keeps the agreed state
        if (a.we) model_a[a.addr] = a.data;
        if (b.we) model_b[b.addr] = b.data;
        model_busy = 1'b1;
      end else if (a.we) begin
        model_a[a.addr]      = a.data;
        model_b[a.addr]      = a.data;
        model_shadow[a.addr] = a.data;
      end
    end
  endfunction

  function automatic dmr_rf_pkg::rf_wr_t random_write();
    dmr_rf_pkg::rf_wr_t w;
    w.we   = 1'b1;
    w.addr = `DMR_RF_ADDR_W'($urandom());
    w.data = $urandom();
    return w;
  endfunction

  task automatic issue_write(input dmr_rf_pkg::rf_wr_t a, input dmr_rf_pkg::rf_wr_t b);
    @(posedge clk);
    wr_a <= a;
    wr_b <= b;
    model_write(a, b);
  endtask

  task automatic idle_ports();
    @(posedge clk);
    wr_a <= '0;
    wr_b <= '0;
  endtask

  task automatic read_pair(input string test_name, input logic [`DMR_RF_ADDR_W-1:0] addr,
                           input logic [31:0] exp_a, input logic [31:0] exp_b);
    @(posedge clk);
    rd_a.addr <= addr;
    rd_b.addr <= addr;
    @(negedge clk);
    check_value(test_name, $sformatf("port a reg %0d", addr), exp_a, rd_data_a);
    check_value(test_name, $sformatf("port b reg %0d", addr), exp_b, rd_data_b);
  endtask

  task automatic compare_all_regs(input string test_name, input logic from_shadow);
    for (int i = 0; i < `DMR_RF_NUM_REGS; i++) begin
      if (from_shadow) begin
        read_pair(test_name, `DMR_RF_ADDR_W'(i), model_shadow[i], model_shadow[i]);
      end else begin
        read_pair(test_name, `DMR_RF_ADDR_W'(i), model_a[i], model_b[i]);
      end
    end
  endtask

  // ************************************************************************
  // halt handshake, acting as both cores
  // ************************************************************************

  task automatic answer_halt(input string test_name);
    int delay;
    int steps;
    // req must rise together with busy
    while (busy !== 1'b1) @(negedge clk);
    check_flags(test_name, 1'b1, 1'b1, 1'b1);
    // cores need a few cycles to halt
    delay = int'($urandom_range(5, 1));
    repeat (delay) @(posedge clk);
    rec_ack <= 1'b1;
    steps = 0;
    do begin
      @(posedge clk);
      @(negedge clk);
      steps++;
    end while (rec_req === 1'b1 && steps < refill_limit);
    // one edge to see ack and then one register per cycle
    check_value(test_name, "edges until rec_req_o low", `DMR_RF_NUM_REGS + 1, steps);
    delay = int'($urandom_range(5, 1));
    repeat (delay) begin
      check_flags(test_name, 1'b1, 1'b0, 1'b1);
      @(negedge clk);
    end
    @(posedge clk);
    rec_ack <= 1'b0;
    @(negedge clk);
    // still releasing until ack low is sampled
    check_flag(test_name, "busy_o", 1'b1, busy);
    @(negedge clk);
    check_flags(test_name, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic finish_recovery(input string test_name);
    answer_halt(test_name);
    // refill copies the shadow into both cores
    for (int i = 0; i < `DMR_RF_NUM_REGS; i++) begin
      model_a[i] = model_shadow[i];
      model_b[i] = model_shadow[i];
    end
    model_busy = 1'b0;
    compare_all_regs(test_name, 1'b1);
  endtask

  // agreed write, mismatch, then writes that must be dropped
  task automatic run_recovery(input string test_name, input dmr_rf_pkg::rf_wr_t a,
                              input dmr_rf_pkg::rf_wr_t b, input int blocked_writes);
    dmr_rf_pkg::rf_wr_t good;
    dmr_rf_pkg::rf_wr_t wa;
    dmr_rf_pkg::rf_wr_t wb;
    good      = a;
    good.we   = 1'b1;
    good.data = $urandom();
    issue_write(good, good);
    issue_write(a, b);
    for (int i = 0; i < blocked_writes; i++) begin
      wa = random_write();
      wb = wa;
      // alternate agreeing and conflicting writes
      if (i % 2 == 1) wb.data = ~wa.data;
      issue_write(wa, wb);
    end
    idle_ports();
    while (rec_req !== 1'b1) @(negedge clk);
    read_pair(test_name, a.addr, model_a[a.addr], model_b[a.addr]);
    read_pair(test_name, b.addr, model_a[b.addr], model_b[b.addr]);
    finish_recovery(test_name);
  endtask

  // ************************************************************************
  // directed tests
  // ************************************************************************

  task automatic test_reset_state();
    @(negedge clk);
    check_flags("reset_state", 1'b0, 1'b0, 1'b0);
    compare_all_regs("reset_state", 1'b0);
  endtask

  task automatic test_matching_writes();
    dmr_rf_pkg::rf_wr_t w;
    dmr_rf_pkg::rf_wr_t quiet_a;
    dmr_rf_pkg::rf_wr_t quiet_b;
    for (int i = 0; i < 20; i++) begin
      w = random_write();
      issue_write(w, w);
      @(negedge clk);
      check_flag("matching_writes", "busy_o", 1'b0, busy);
    end
    // with both enables clear the address and data are don't care
    quiet_a    = random_write();
    quiet_a.we = 1'b0;
    quiet_b    = random_write();
    quiet_b.we = 1'b0;
    issue_write(quiet_a, quiet_b);
    idle_ports();
    @(negedge clk);
    check_flags("matching_writes", 1'b0, 1'b0, 1'b0);
    compare_all_regs("matching_writes", 1'b0);
  endtask

  task automatic test_data_mismatch();
    dmr_rf_pkg::rf_wr_t a;
    dmr_rf_pkg::rf_wr_t b;
    a = random_write();
    issue_write(a, a);
    a.data = $urandom();
    b      = a;
    b.data = a.data ^ ($urandom() | 32'h1);
    issue_write(a, b);
    idle_ports();
    @(negedge clk);
    // pulse registered while the controller is still idle
    check_flags("data_mismatch", 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    check_flags("data_mismatch", 1'b1, 1'b1, 1'b1);
    read_pair("data_mismatch", a.addr, model_a[a.addr], model_b[a.addr]);
    finish_recovery("data_mismatch");
  endtask

  task automatic test_busy_writes();
    dmr_rf_pkg::rf_wr_t a;
    dmr_rf_pkg::rf_wr_t b;
    a      = random_write();
    b      = a;
    b.data = ~a.data;
    run_recovery("busy_writes", a, b, 8);
  endtask

  task automatic test_enable_mismatch();
    dmr_rf_pkg::rf_wr_t a;
    dmr_rf_pkg::rf_wr_t b;
    a    = random_write();
    b    = a;
    b.we = 1'b0;
    run_recovery("enable_mismatch", a, b, 0);
  endtask

  task automatic test_address_mismatch();
    dmr_rf_pkg::rf_wr_t a;
    dmr_rf_pkg::rf_wr_t b;
    a      = random_write();
    b      = a;
    b.addr = a.addr + 1'b1;
    run_recovery("address_mismatch", a, b, 0);
  endtask

  // ************************************************************************
  // run control
  // ************************************************************************

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", cycle_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed_value  = $urandom(32'h255a);
    error_count = 0;
    check_count = 0;
    rst_n   <= 1'b0;
    rec_ack <= 1'b0;
    wr_a    <= '0;
    wr_b    <= '0;
    rd_a    <= '0;
    rd_b    <= '0;
    for (int i = 0; i < `DMR_RF_NUM_REGS; i++) begin
      model_a[i]      = '0;
      model_b[i]      = '0;
      model_shadow[i] = '0;
    end
    model_busy = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_matching_writes();
    test_data_mismatch();
    test_busy_writes();
    test_enable_mismatch();
    test_address_mismatch();
    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+common
common/dmr_rf_pkg.sv
source/tmr_bitwise_voter.sv
recovery/rf_refill_addr_gen.sv
recovery/rf_recovery_ctrl.sv
source/core_reg_file.sv
source/dmr_rf_top.sv
verification/tb_dmr_rf_top.sv

//--- Makefile
# verilator build and run of the dmr register file testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_dmr_rf_top
FILELIST  = build.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   = $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
